// ==== hw/blob_sort_macros.svh ====
`ifndef BLOB_SORT_MACROS_SVH
`define BLOB_SORT_MACROS_SVH

// main memory port
`define BS_ADDR_W 18
`define BS_DATA_W 32

// blob records left by the extraction stage
// three words per record, word 2 unused here
`define BS_BLOB_BASE 200000
`define BS_REC_STRIDE 3

// rank table geometry
// address = rank * slots + slot - 1
`define BS_NUM_SLOTS 6
`define BS_NUM_RANKS 3
`define BS_TABLE_DEPTH 18
`define BS_TABLE_AW 5

// key word and blob counter widths
`define BS_KEY_W 16
`define BS_COUNT_W 16

// sort criteria, sampled from sort_mode at pass start
`define BS_MODE_BIGGEST 2'd0
`define BS_MODE_SMALLEST 2'd1
`define BS_MODE_Y_HIGH 2'd2
`define BS_MODE_Y_LOW 2'd3

`endif

// ==== hw/blob_sort_pkg.sv ====
`default_nettype none

`include "blob_sort_macros.svh"

package blob_sort_pkg;

	// one table key word, read two ways depending on sort mode
	// size modes use the full 16-bit blob size
	// y modes keep x in the high byte and y in the low byte
	typedef union packed {
		logic [`BS_KEY_W-1:0] size;
		logic [1:0][7:0] coord;
	} rank_key_u;

endpackage

`default_nettype wire

// ==== hw/blob_record_fetch.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "blob_sort_macros.svh"

module blob_record_fetch (
	input logic clk,
	input logic rst_n,
	input logic sort_enable,
	input logic [1:0] sort_mode,
	input logic [`BS_COUNT_W-1:0] blob_count,
	input logic [`BS_DATA_W-1:0] mem_rdata,
	output logic [`BS_ADDR_W-1:0] mem_addr,
	output logic table_clear,
	output logic rec_valid,
	output logic [2:0] rec_slot,
	output blob_sort_pkg::rank_key_u rec_key,
	output logic [`BS_ADDR_W-1:0] rec_ptr,
	output logic [1:0] cmp_mode,
	output logic [`BS_COUNT_W-1:0] valid_blobs,
	output logic sort_done
);

	// walk states, one address and one data cycle per word
	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ADDR0 = 3'd1;
	localparam logic [2:0] S_DATA0 = 3'd2;
	localparam logic [2:0] S_ADDR1 = 3'd3;
	localparam logic [2:0] S_DATA1 = 3'd4;
	localparam logic [2:0] S_DRAIN = 3'd5;
	localparam logic [2:0] S_DONE = 3'd6;

	logic [2:0] state;
	logic sort_en_q;
	logic start;
	logic [1:0] mode_q;
	logic [`BS_COUNT_W-1:0] count_q;
	logic [`BS_COUNT_W-1:0] rec_idx;
	logic [`BS_ADDR_W-1:0] rec_base;
	logic slot_ok;
	logic last_rec;

	// pass starts on the rising edge of sort_enable
	assign start = sort_enable && !sort_en_q && (state == S_IDLE);
	assign table_clear = start;

	// color slot lives in the low byte of word 0, only 1..6 are kept
	assign slot_ok = (mem_rdata[7:0] != 8'd0) && (mem_rdata[7:0] <= 8'(`BS_NUM_SLOTS));
	assign last_rec = (rec_idx + 1'b1 == count_q);

	// word 1 sits right after word 0
	assign mem_addr = (state == S_ADDR1) ? rec_base + `BS_ADDR_W'(1) : rec_base;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			sort_en_q <= 1'b0;
			mode_q <= `BS_MODE_BIGGEST;
			count_q <= '0;
			rec_idx <= '0;
			rec_base <= `BS_ADDR_W'(`BS_BLOB_BASE);
			valid_blobs <= '0;
		end else begin
			sort_en_q <= sort_enable;
			if (!sort_enable) begin
				// enable low idles the walker and drops sort_done
				state <= S_IDLE;
			end else begin
				case (state)
					S_IDLE: begin
						if (start) begin
							mode_q <= sort_mode;
							count_q <= blob_count;
							rec_idx <= '0;
							rec_base <= `BS_ADDR_W'(`BS_BLOB_BASE);
							valid_blobs <= '0;
							state <= (blob_count == '0) ? S_DRAIN : S_ADDR0;
						end
					end
					S_ADDR0: state <= S_ADDR0 + 3'd1;
					S_DATA0: begin
						if (slot_ok) begin
							valid_blobs <= valid_blobs + 1'b1;
							state <= S_ADDR1;
						end else if (last_rec) begin
							state <= S_DRAIN;
						end else begin
							// rejected, skip straight to next record
							rec_idx <= rec_idx + 1'b1;
							rec_base <= rec_base + `BS_ADDR_W'(`BS_REC_STRIDE);
							state <= S_ADDR0;
						end
					end
					S_ADDR1: state <= S_DATA1;
					S_DATA1: begin
						rec_idx <= rec_idx + 1'b1;
						rec_base <= rec_base + `BS_ADDR_W'(`BS_REC_STRIDE);
						state <= last_rec ? S_DRAIN : S_ADDR0;
					end
					// lets the last insert land before done is raised
					S_DRAIN: state <= S_DONE;
					S_DONE: state <= S_DONE;
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// slot of the accepted record, held through its word 1 read
	always_ff @(posedge clk) begin
		if ((state == S_DATA0) && slot_ok) begin
			rec_slot <= mem_rdata[2:0];
		end
	end

	// key built straight from word 1 in its data cycle
	always_comb begin
		if ((mode_q == `BS_MODE_Y_HIGH) || (mode_q == `BS_MODE_Y_LOW)) begin
			rec_key.coord = mem_rdata[31:16];
		end else begin
			rec_key.size = mem_rdata[15:0];
		end
	end

	assign rec_valid = (state == S_DATA1);
	// pointer to word 0 of the record
	assign rec_ptr = rec_base;
	assign cmp_mode = mode_q;
	assign sort_done = (state == S_DONE);

	// compare stage relies on a gap between records
	a_rec_valid_gap: assert property (@(posedge clk) disable iff (!rst_n)
		rec_valid |=> !rec_valid);

endmodule

`default_nettype wire

// ==== hw/rank_compare.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "blob_sort_macros.svh"

module rank_compare (
	input logic clk,
	input logic rst_n,
	input logic [1:0] cmp_mode,
	input logic rec_valid,
	input logic [2:0] rec_slot,
	input blob_sort_pkg::rank_key_u rec_key,
	input logic [`BS_ADDR_W-1:0] rec_ptr,
	input blob_sort_pkg::rank_key_u [`BS_NUM_RANKS-1:0] cmp_keys,
	input logic [`BS_NUM_RANKS-1:0] cmp_valids,
	output logic ins_valid,
	output logic [2:0] ins_slot,
	output logic [1:0] ins_rank,
	output blob_sort_pkg::rank_key_u ins_key,
	output logic [`BS_ADDR_W-1:0] ins_ptr
);

	logic [`BS_NUM_RANKS-1:0] better;
	logic [`BS_NUM_RANKS-1:0] beats;
	logic [1:0] first_rank;

	// strict compare per rank, ties keep the stored blob on top
	// y modes look only at the y byte
	always_comb begin
		for (int r = 0; r < `BS_NUM_RANKS; r++) begin
			case (cmp_mode)
				`BS_MODE_BIGGEST: better[r] = rec_key.size > cmp_keys[r].size;
				`BS_MODE_SMALLEST: better[r] = rec_key.size < cmp_keys[r].size;
				`BS_MODE_Y_HIGH: better[r] = rec_key.coord[0] > cmp_keys[r].coord[0];
				default: better[r] = rec_key.coord[0] < cmp_keys[r].coord[0];
			endcase
			// empty entry always loses
			beats[r] = better[r] || !cmp_valids[r];
		end
	end

	// highest rank that is beaten wins, 3 means no insert
	always_comb begin
		first_rank = 2'd3;
		for (int r = `BS_NUM_RANKS - 1; r >= 0; r--) begin
			if (beats[r]) begin
				first_rank = 2'(r);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ins_valid <= 1'b0;
		end else begin
			ins_valid <= rec_valid && (|beats);
		end
	end

	always_ff @(posedge clk) begin
		if (rec_valid) begin
			ins_slot <= rec_slot;
			ins_rank <= first_rank;
			ins_key <= rec_key;
			ins_ptr <= rec_ptr;
		end
	end

	a_ins_rank_range: assert property (@(posedge clk) disable iff (!rst_n)
		ins_valid |-> (ins_rank != 2'd3));

endmodule

`default_nettype wire

// ==== hw/rank_store.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "blob_sort_macros.svh"

module rank_store (
	input logic clk,
	input logic rst_n,
	input logic table_clear,
	input logic [2:0] rec_slot,
	input logic ins_valid,
	input logic [2:0] ins_slot,
	input logic [1:0] ins_rank,
	input blob_sort_pkg::rank_key_u ins_key,
	input logic [`BS_ADDR_W-1:0] ins_ptr,
	input logic [`BS_TABLE_AW-1:0] rank_rd_addr,
	output blob_sort_pkg::rank_key_u [`BS_NUM_RANKS-1:0] cmp_keys,
	output logic [`BS_NUM_RANKS-1:0] cmp_valids,
	output blob_sort_pkg::rank_key_u rank_rd_key,
	output logic [`BS_ADDR_W-1:0] rank_rd_ptr,
	output logic rank_rd_valid
);

	import blob_sort_pkg::*;

	// register file, so a whole slot is visible in one cycle
	rank_key_u key_mem [`BS_TABLE_DEPTH];
	logic [`BS_ADDR_W-1:0] ptr_mem [`BS_TABLE_DEPTH];
	logic [`BS_TABLE_DEPTH-1:0] valid_mem;

	// rank-major layout, rank one at 0..5
	function automatic logic [`BS_TABLE_AW-1:0] tbl_addr(input logic [1:0] rank,
			input logic [2:0] slot);
		return `BS_TABLE_AW'(rank * `BS_NUM_SLOTS + slot - 1);
	endfunction

	// three entries of the slot under compare
	always_comb begin
		for (int r = 0; r < `BS_NUM_RANKS; r++) begin
			cmp_keys[r] = key_mem[tbl_addr(2'(r), rec_slot)];
			cmp_valids[r] = valid_mem[tbl_addr(2'(r), rec_slot)];
		end
	end

	// insert shifts lower ranks down, old rank three falls off
	always_ff @(posedge clk) begin
		if (ins_valid) begin
			for (int r = 0; r < `BS_NUM_RANKS; r++) begin
				if (r == ins_rank) begin
					key_mem[tbl_addr(2'(r), ins_slot)] <= ins_key;
					ptr_mem[tbl_addr(2'(r), ins_slot)] <= ins_ptr;
				end else if (r > ins_rank) begin
					key_mem[tbl_addr(2'(r), ins_slot)] <= key_mem[tbl_addr(2'(r - 1), ins_slot)];
					ptr_mem[tbl_addr(2'(r), ins_slot)] <= ptr_mem[tbl_addr(2'(r - 1), ins_slot)];
				end
			end
		end
	end

	// valid bits follow the same shift, clear wipes the table
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_mem <= '0;
		end else if (table_clear) begin
			valid_mem <= '0;
		end else if (ins_valid) begin
			for (int r = 0; r < `BS_NUM_RANKS; r++) begin
				if (r == ins_rank) begin
					valid_mem[tbl_addr(2'(r), ins_slot)] <= 1'b1;
				end else if (r > ins_rank) begin
					valid_mem[tbl_addr(2'(r), ins_slot)] <= valid_mem[tbl_addr(2'(r - 1), ins_slot)];
				end
			end
		end
	end

	// read port for the next stage, one cycle latency
	always_ff @(posedge clk) begin
		rank_rd_key <= key_mem[rank_rd_addr];
		rank_rd_ptr <= ptr_mem[rank_rd_addr];
	end

	// addresses past the table read as empty
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rank_rd_valid <= 1'b0;
		end else begin
			rank_rd_valid <= (rank_rd_addr < `BS_TABLE_AW'(`BS_TABLE_DEPTH)) &&
				valid_mem[rank_rd_addr];
		end
	end

	// fetch filter must keep bad slots out of the table
	a_ins_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
		ins_valid |-> ((ins_slot >= 3'd1) && (ins_slot <= 3'(`BS_NUM_SLOTS))));

endmodule

`default_nettype wire

// ==== hw/blob_sorter.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "blob_sort_macros.svh"

module blob_sorter (
	input logic clk,
	input logic rst_n,
	input logic sort_enable,
	input logic [1:0] sort_mode,
	input logic [`BS_COUNT_W-1:0] blob_count,
	input logic [`BS_DATA_W-1:0] mem_rdata,
	input logic [`BS_TABLE_AW-1:0] rank_rd_addr,
	output logic [`BS_ADDR_W-1:0] mem_addr,
	output logic [`BS_COUNT_W-1:0] valid_blobs,
	output logic sort_done,
	output blob_sort_pkg::rank_key_u rank_rd_key,
	output logic [`BS_ADDR_W-1:0] rank_rd_ptr,
	output logic rank_rd_valid
);

	import blob_sort_pkg::*;

	// fetch to compare
	logic table_clear;
	logic rec_valid;
	logic [2:0] rec_slot;
	rank_key_u rec_key;
	logic [`BS_ADDR_W-1:0] rec_ptr;
	logic [1:0] cmp_mode;

	// store to compare, entries of the current slot
	rank_key_u [`BS_NUM_RANKS-1:0] cmp_keys;
	logic [`BS_NUM_RANKS-1:0] cmp_valids;

	// compare to store
	logic ins_valid;
	logic [2:0] ins_slot;
	logic [1:0] ins_rank;
	rank_key_u ins_key;
	logic [`BS_ADDR_W-1:0] ins_ptr;

	blob_record_fetch u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.sort_enable(sort_enable),
		.sort_mode(sort_mode),
		.blob_count(blob_count),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.table_clear(table_clear),
		.rec_valid(rec_valid),
		.rec_slot(rec_slot),
		.rec_key(rec_key),
		.rec_ptr(rec_ptr),
		.cmp_mode(cmp_mode),
		.valid_blobs(valid_blobs),
		.sort_done(sort_done)
	);

	rank_compare u_compare (
		.clk(clk),
		.rst_n(rst_n),
		.cmp_mode(cmp_mode),
		.rec_valid(rec_valid),
		.rec_slot(rec_slot),
		.rec_key(rec_key),
		.rec_ptr(rec_ptr),
		.cmp_keys(cmp_keys),
		.cmp_valids(cmp_valids),
		.ins_valid(ins_valid),
		.ins_slot(ins_slot),
		.ins_rank(ins_rank),
		.ins_key(ins_key),
		.ins_ptr(ins_ptr)
	);

	rank_store u_store (
		.clk(clk),
		.rst_n(rst_n),
		.table_clear(table_clear),
		.rec_slot(rec_slot),
		.ins_valid(ins_valid),
		.ins_slot(ins_slot),
		.ins_rank(ins_rank),
		.ins_key(ins_key),
		.ins_ptr(ins_ptr),
		.rank_rd_addr(rank_rd_addr),
		.cmp_keys(cmp_keys),
		.cmp_valids(cmp_valids),
		.rank_rd_key(rank_rd_key),
		.rank_rd_ptr(rank_rd_ptr),
		.rank_rd_valid(rank_rd_valid)
	);

endmodule

`default_nettype wire

// ==== dv/tb_blob_sorter.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "blob_sort_macros.svh"

module tb_blob_sorter;

	import blob_sort_pkg::*;

	localparam int NUM_ROWS = 7;
	localparam int MAX_RECS = 48;
	localparam int MEM_WORDS = MAX_RECS * `BS_REC_STRIDE;

	// scenario table with one column per field
	// slot range 0..9 puts rejects into the records
	// row 4 follows a bigger pass so most of its table must read back empty
	localparam logic [1:0] ROW_MODE [NUM_ROWS] = '{`BS_MODE_BIGGEST, `BS_MODE_SMALLEST,
		`BS_MODE_Y_HIGH, `BS_MODE_Y_LOW, `BS_MODE_BIGGEST, `BS_MODE_SMALLEST, `BS_MODE_Y_HIGH};
	localparam int ROW_COUNT [NUM_ROWS] = '{40, 40, 30, 30, 3, 0, 12};
	localparam int ROW_SLOT_LO [NUM_ROWS] = '{1, 0, 1, 0, 1, 1, 0};
	localparam int ROW_SLOT_HI [NUM_ROWS] = '{6, 9, 6, 9, 6, 6, 9};

	logic clk = 1'b0;
	logic rst_n;
	logic sort_enable;
	logic [1:0] sort_mode;
	logic [`BS_COUNT_W-1:0] blob_count;
	logic [`BS_DATA_W-1:0] mem_rdata;
	logic [`BS_TABLE_AW-1:0] rank_rd_addr;
	logic [`BS_ADDR_W-1:0] mem_addr;
	logic [`BS_COUNT_W-1:0] valid_blobs;
	logic sort_done;
	rank_key_u rank_rd_key;
	logic [`BS_ADDR_W-1:0] rank_rd_ptr;
	logic rank_rd_valid;

	// memory model storage with word 0 at the blob base
	logic [`BS_DATA_W-1:0] mem [MEM_WORDS];
	logic [`BS_ADDR_W-1:0] addr_q;
	logic [31:0] rng;

	// expected table from the reference model
	rank_key_u exp_key [`BS_TABLE_DEPTH];
	logic [`BS_ADDR_W-1:0] exp_ptr [`BS_TABLE_DEPTH];
	logic exp_valid [`BS_TABLE_DEPTH];
	int exp_blobs;
	int exp_latency;

	int cycles = 0;
	int cycle_limit;
	int errors;
	int rows_passed;
	int rows_failed;

	blob_sorter dut (
		.clk(clk),
		.rst_n(rst_n),
		.sort_enable(sort_enable),
		.sort_mode(sort_mode),
		.blob_count(blob_count),
		.mem_rdata(mem_rdata),
		.rank_rd_addr(rank_rd_addr),
		.mem_addr(mem_addr),
		.valid_blobs(valid_blobs),
		.sort_done(sort_done),
		.rank_rd_key(rank_rd_key),
		.rank_rd_ptr(rank_rd_ptr),
		.rank_rd_valid(rank_rd_valid)
	);

	always #2 clk = ~clk;

	// background word built from every address bit
	function automatic logic [`BS_DATA_W-1:0] fill_word(input logic [`BS_ADDR_W-1:0] addr);
		return {addr[13:0], addr};
	endfunction

	function automatic logic [`BS_DATA_W-1:0] read_word(input logic [`BS_ADDR_W-1:0] addr);
		int offset;
		offset = int'(addr) - `BS_BLOB_BASE;
		if (offset >= 0 && offset < MEM_WORDS) begin
			return mem[offset];
		end
		return fill_word(addr);
	endfunction

	// address captured mid cycle and answered in the following cycle
	always @(negedge clk) begin
		addr_q <= mem_addr;
		mem_rdata <= read_word(addr_q);
	end

	// the walk reads only words 0 and 1 and stays inside the record area
	always @(negedge clk) begin
		int offset;
		offset = int'(mem_addr) - `BS_BLOB_BASE;
		assert (offset >= 0 && offset <= MEM_WORDS && offset % `BS_REC_STRIDE != 2) else begin
			$display("mem_addr 0x%0h at %0t ns is not word 0 or word 1 of a record",
				mem_addr, $time);
			errors++;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// random records with small fields so that equal keys are common
	task automatic fill_records(input int count, input int slot_lo, input int slot_hi);
		int span;
		int w;
		span = slot_hi - slot_lo + 1;
		for (int i = 0; i < count; i++) begin
			w = i * `BS_REC_STRIDE;
			rng = xorshift32(rng);
			// only the low byte of word 0 is the slot and the upper bytes are junk
			mem[w] = {rng[31:8], 8'(slot_lo + int'(rng[7:0]) % span)};
			rng = xorshift32(rng);
			// x in 0..15 and y in 0..7 with size in 0..31
			mem[w + 1] = {4'h0, rng[3:0], 5'h0, rng[10:8], 11'h0, rng[20:16]};
			rng = xorshift32(rng);
			mem[w + 2] = rng;
		end
	endtask

	function automatic int table_index(input int rank, input int slot);
		return rank * `BS_NUM_SLOTS + slot - 1;
	endfunction

	// ranking value is the y byte in the y modes and the size otherwise
	function automatic int rank_score(input logic [1:0] mode, input rank_key_u key);
		if (mode == `BS_MODE_Y_HIGH || mode == `BS_MODE_Y_LOW) begin
			return int'(key.size[7:0]);
		end
		return int'(key.size);
	endfunction

	// empty entries always lose and equal scores keep the stored blob
	function automatic bit new_blob_wins(input logic [1:0] mode, input rank_key_u new_key,
			input rank_key_u old_key, input logic old_valid);
		int a;
		int b;
		a = rank_score(mode, new_key);
		b = rank_score(mode, old_key);
		if (!old_valid) begin
			return 1'b1;
		end
		if (mode == `BS_MODE_BIGGEST || mode == `BS_MODE_Y_HIGH) begin
			return a > b;
		end
		return a < b;
	endfunction

	// reference model for the table contents and accepted count plus done latency
	task automatic build_expected(input logic [1:0] mode, input int count);
		int slot;
		int ins;
		int w;
		rank_key_u key;
		exp_blobs = 0;
		// start cycle to done is the record cycles plus the drain
		exp_latency = 2;
		for (int a = 0; a < `BS_TABLE_DEPTH; a++) begin
			exp_valid[a] = 1'b0;
			exp_key[a] = '0;
			exp_ptr[a] = '0;
		end
		for (int i = 0; i < count; i++) begin
			w = i * `BS_REC_STRIDE;
			slot = int'(mem[w][7:0]);
			if (slot == 0 || slot > `BS_NUM_SLOTS) begin
				exp_latency += 2;
			end else begin
				exp_blobs++;
				exp_latency += 4;
				if (mode == `BS_MODE_Y_HIGH || mode == `BS_MODE_Y_LOW) begin
					key.coord = mem[w + 1][31:16];
				end else begin
					key.size = mem[w + 1][15:0];
				end
				ins = `BS_NUM_RANKS;
				for (int r = 0; r < `BS_NUM_RANKS; r++) begin
					if (ins == `BS_NUM_RANKS && new_blob_wins(mode, key,
							exp_key[table_index(r, slot)], exp_valid[table_index(r, slot)])) begin
						ins = r;
					end
				end
				if (ins < `BS_NUM_RANKS) begin
					// push the lower ranks down so the last one falls off
					for (int r = `BS_NUM_RANKS - 1; r > ins; r--) begin
						exp_key[table_index(r, slot)] = exp_key[table_index(r - 1, slot)];
						exp_ptr[table_index(r, slot)] = exp_ptr[table_index(r - 1, slot)];
						exp_valid[table_index(r, slot)] = exp_valid[table_index(r - 1, slot)];
					end
					exp_key[table_index(ins, slot)] = key;
					exp_ptr[table_index(ins, slot)] = `BS_ADDR_W'(`BS_BLOB_BASE + w);
					exp_valid[table_index(ins, slot)] = 1'b1;
				end
			end
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected,
				actual);
			errors++;
		end
	endtask

	// read data is registered so each address is checked on the next falling edge
	task automatic readback_table();
		for (int a = 0; a < `BS_TABLE_DEPTH; a++) begin
			rank_rd_addr = `BS_TABLE_AW'(a);
			@(negedge clk);
			compare_value($sformatf("rank_rd_valid[%0d]", a), 32'(exp_valid[a]),
				32'(rank_rd_valid));
			if (exp_valid[a]) begin
				compare_value($sformatf("rank_rd_key[%0d]", a), 32'(exp_key[a]),
					32'(rank_rd_key));
				compare_value($sformatf("rank_rd_ptr[%0d]", a), 32'(exp_ptr[a]),
					32'(rank_rd_ptr));
			end
		end
	endtask

	// run limit from the pass lengths plus readback and a margin
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		int row_errors;
		int wait_cycles;
		rst_n = 1'b0;
		sort_enable = 1'b0;
		sort_mode = `BS_MODE_BIGGEST;
		blob_count = '0;
		rank_rd_addr = '0;
		mem_rdata = '0;
		rng = 32'd93;
		errors = 0;
		rows_passed = 0;
		rows_failed = 0;
		cycle_limit = 100;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycle_limit += ROW_COUNT[r] * 4 + 20 + 2 * `BS_TABLE_DEPTH;
		end
		for (int w = 0; w < MEM_WORDS; w++) begin
			mem[w] = fill_word(`BS_ADDR_W'(`BS_BLOB_BASE + w));
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		for (int row = 0; row < NUM_ROWS; row++) begin
			row_errors = errors;
			fill_records(ROW_COUNT[row], ROW_SLOT_LO[row], ROW_SLOT_HI[row]);
			build_expected(ROW_MODE[row], ROW_COUNT[row]);
			@(negedge clk);
			sort_mode = ROW_MODE[row];
			blob_count = `BS_COUNT_W'(ROW_COUNT[row]);
			sort_enable = 1'b1;
			wait_cycles = 0;
			do begin
				@(negedge clk);
				wait_cycles++;
			end while (!sort_done);
			compare_value("sort_done latency", 32'(exp_latency), 32'(wait_cycles));
			compare_value("valid_blobs", 32'(exp_blobs), 32'(valid_blobs));
			readback_table();
			// enable low ends the pass and drops done
			sort_enable = 1'b0;
			@(negedge clk);
			compare_value("sort_done", 32'd0, 32'(sort_done));
			if (errors == row_errors) begin
				rows_passed++;
			end else begin
				rows_failed++;
			end
			$display("row %0d: mode %0d, %0d records, %0d accepted, %0d errors", row,
				ROW_MODE[row], ROW_COUNT[row], exp_blobs, errors - row_errors);
		end
		$display("rows passed %0d, rows failed %0d, errors %0d", rows_passed, rows_failed,
			errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== blob_sorter.f ====
+incdir+hw
hw/blob_sort_pkg.sv
hw/blob_record_fetch.sv
hw/rank_compare.sv
hw/rank_store.sv
hw/blob_sorter.sv
dv/tb_blob_sorter.sv

// ==== Bender.yml ====
package:
  name: blob_sorter

sources:
  - include_dirs:
      - hw
    files:
      - hw/blob_sort_pkg.sv
      - hw/blob_record_fetch.sv
      - hw/rank_compare.sv
      - hw/rank_store.sv
      - hw/blob_sorter.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_blob_sorter.sv
